/* Makefile */
# Verilator build and run of the UDP checksum generator testbench

TOP := tb_udp_checksum_gen

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f flist.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* flist.f */
udp_csum_pkg.sv
udp_csum_accum.sv
udp_payload_fifo.sv
udp_hdr_queue.sv
udp_checksum_gen.sv
udp_checksum_gen_sva.sv
tb_udp_checksum_gen.sv

/* tb_udp_checksum_gen.sv */
// table-driven testbench for the UDP length and checksum generator
// small buffer depths so random back-pressure fills both buffers
// expected checksums follow the ones-complement rule over the stored payload bytes
module tb_udp_checksum_gen;

    timeunit 1ns;
    timeprecision 1ps;

    import udp_csum_pkg::*;

    localparam int PAYLOAD_DEPTH = 16;
    localparam int HDR_DEPTH = 2;
    localparam int N_FRAMES = 7;
    localparam int WAIT_LIMIT = 2000;

    // src ip, dst ip, src port, dst port, payload bytes, expected UDP length
    localparam logic [127:0] FRAMES [N_FRAMES] = '{
        {32'hC0A8_0001, 32'hC0A8_0002, 16'h1234, 16'h0050, 16'd1,  16'd9},
        {32'h0A00_0001, 32'h0A00_00FE, 16'h0035, 16'hC350, 16'd2,  16'd10},
        {32'hAC10_0A01, 32'hAC10_0A02, 16'hFFFF, 16'h0001, 16'd7,  16'd15},
        {32'hFFFF_FFFF, 32'h0000_0000, 16'h8000, 16'h7FFF, 16'd16, 16'd24},
        {32'h7F00_0001, 32'h7F00_0001, 16'h1F90, 16'h1F90, 16'd33, 16'd41},
        {32'hE000_00FB, 32'hC0A8_0101, 16'h14E9, 16'h14E9, 16'd3,  16'd11},
        {32'h6440_0001, 32'h6440_00FF, 16'h0007, 16'h0009, 16'd40, 16'd48}
    };

    logic     clk;
    logic     rst = 1'b1;
    logic     s_hdr_valid = 1'b0;
    logic     s_hdr_ready;
    ip_addr_u s_ip_src = '0;
    ip_addr_u s_ip_dst = '0;
    port_t    s_src_port = '0;
    port_t    s_dst_port = '0;
    byte_t    s_payload_tdata = '0;
    logic     s_payload_tvalid = 1'b0;
    logic     s_payload_tready;
    logic     s_payload_tlast = 1'b0;
    logic     m_hdr_valid;
    logic     m_hdr_ready = 1'b0;
    ip_addr_u m_ip_src;
    ip_addr_u m_ip_dst;
    port_t    m_src_port;
    port_t    m_dst_port;
    word16_t  m_udp_length;
    word16_t  m_udp_checksum;
    byte_t    m_payload_tdata;
    logic     m_payload_tvalid;
    logic     m_payload_tready = 1'b0;
    logic     m_payload_tlast;

    integer   seed = 32'h5662;
    int       hdrs_taken = 0;
    logic     hdrs_done = 1'b0;
    logic     bytes_done = 1'b0;
    byte_t    pay_bytes [$];
    word16_t  exp_csum [$];

    udp_checksum_gen #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .HDR_DEPTH     (HDR_DEPTH)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pseudo-header, UDP header and payload as big-endian 16-bit words
    function automatic word16_t expected_checksum(input logic [127:0] row, input int first);
        ip_addr_u    src;
        ip_addr_u    dst;
        int          count;
        int          i;
        logic [31:0] acc;
        logic [7:0]  low;
        src = row[127:96];
        dst = row[95:64];
        count = int'(row[31:16]);
        acc = 32'h0011 + 2 * 32'(count + 8) + 32'(row[63:48]) + 32'(row[47:32]);
        acc = acc + 32'(src.halves.hi) + 32'(src.halves.lo);
        acc = acc + 32'(dst.halves.hi) + 32'(dst.halves.lo);
        for (i = 0; i < count; i += 2) begin
            // odd last byte gets a zero low byte
            low = (i + 1 < count) ? pay_bytes[first + i + 1] : 8'h00;
            acc = acc + 32'({pay_bytes[first + i], low});
        end
        while (acc[31:16] != 16'h0) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        return ~acc[15:0];
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic next_cycle(inout int cycles, input string what);
        @(posedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            $display("timed out after %0d cycles %s", WAIT_LIMIT, what);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input ip_addr_u got, input ip_addr_u exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got.word, exp.word);
            stop_on_error();
        end
    endtask

    task automatic check_port(input string name, input port_t got, input port_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input word16_t got, input word16_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp,
                              input logic got_last, input logic exp_last);
        if (got !== exp || got_last !== exp_last) begin
            $display("CHECK FAILED %s got %h last %h expected %h last %h",
                     name, got, got_last, exp, exp_last);
            stop_on_error();
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("s_hdr_ready", s_hdr_ready, 1'b0);
        check_flag("s_payload_tready", s_payload_tready, 1'b0);
        check_flag("m_hdr_valid", m_hdr_valid, 1'b0);
        check_flag("m_payload_tvalid", m_payload_tvalid, 1'b0);
    endtask

    // header side stalls most cycles so the header queue fills
    initial begin
        forever begin
            @(posedge clk);
            if (!rst) begin
                m_hdr_ready <= (($random(seed) & 15) == 0);
                m_payload_tready <= (($random(seed) & 1) != 0);
            end
        end
    end

    initial begin
        int f;
        int i;
        int pos;
        int len;
        int cycles;
        int hdrs_sent;
        pos = 0;
        for (f = 0; f < N_FRAMES; f++) begin
            len = int'(FRAMES[f][31:16]);
            for (i = 0; i < len; i++) begin
                pay_bytes.push_back(byte_t'($random(seed)));
            end
            exp_csum.push_back(expected_checksum(FRAMES[f], pos));
            pos += len;
        end

        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_idle_outputs();
            end
        end
        rst <= 1'b0;
        @(posedge clk);
        check_idle_outputs();

        hdrs_sent = 0;
        pos = 0;
        for (f = 0; f < N_FRAMES; f++) begin
            s_ip_src <= FRAMES[f][127:96];
            s_ip_dst <= FRAMES[f][95:64];
            s_src_port <= FRAMES[f][63:48];
            s_dst_port <= FRAMES[f][47:32];
            s_hdr_valid <= 1'b1;
            cycles = 0;
            do begin
                next_cycle(cycles, "waiting for s_hdr_ready");
            end while (!s_hdr_ready);
            // queue memory plus output register is all that can be pending
            if (hdrs_sent - hdrs_taken > HDR_DEPTH + 1) begin
                $display("header accepted while %0d headers were still pending",
                         hdrs_sent - hdrs_taken);
                stop_on_error();
            end
            hdrs_sent++;
            s_hdr_valid <= 1'b0;
            len = int'(FRAMES[f][31:16]);
            for (i = 0; i < len; i++) begin
                s_payload_tdata <= pay_bytes[pos + i];
                s_payload_tlast <= (i == len - 1);
                s_payload_tvalid <= 1'b1;
                cycles = 0;
                do begin
                    next_cycle(cycles, "waiting for s_payload_tready");
                end while (!s_payload_tready);
            end
            s_payload_tvalid <= 1'b0;
            s_payload_tlast <= 1'b0;
            pos += len;
        end

        cycles = 0;
        do begin
            next_cycle(cycles, "waiting for the last frames to leave");
        end while (!(hdrs_done && bytes_done));
        $display("No errors");
        $finish;
    end

    // headers must leave in input order
    initial begin
        int f;
        int cycles;
        word16_t csum;
        for (f = 0; f < N_FRAMES; f++) begin
            cycles = 0;
            do begin
                next_cycle(cycles, "waiting for an output header");
            end while (!(m_hdr_valid && m_hdr_ready));
            csum = exp_csum.pop_front();
            check_addr("m_ip_src", m_ip_src, FRAMES[f][127:96]);
            check_addr("m_ip_dst", m_ip_dst, FRAMES[f][95:64]);
            check_port("m_src_port", m_src_port, FRAMES[f][63:48]);
            check_port("m_dst_port", m_dst_port, FRAMES[f][47:32]);
            check_word("m_udp_length", m_udp_length, FRAMES[f][15:0]);
            check_word("m_udp_checksum", m_udp_checksum, csum);
            hdrs_taken <= hdrs_taken + 1;
        end
        hdrs_done <= 1'b1;
    end

    initial begin
        int f;
        int i;
        int pos;
        int len;
        int cycles;
        pos = 0;
        for (f = 0; f < N_FRAMES; f++) begin
            len = int'(FRAMES[f][31:16]);
            for (i = 0; i < len; i++) begin
                cycles = 0;
                do begin
                    next_cycle(cycles, "waiting for an output payload byte");
                end while (!(m_payload_tvalid && m_payload_tready));
                check_byte("m_payload_tdata", m_payload_tdata, pay_bytes[pos],
                           m_payload_tlast, (i == len - 1));
                pos++;
            end
        end
        bytes_done <= 1'b1;
    end

endmodule

/* udp_checksum_gen.sv */
// UDP length and checksum generator, header in parallel, payload as bytes
// payload may leave before its header, m_hdr_valid marks a finished frame
// both depths must be powers of two
module udp_checksum_gen #(
    parameter int PAYLOAD_DEPTH = udp_csum_pkg::DEF_PAYLOAD_DEPTH,
    parameter int HDR_DEPTH     = udp_csum_pkg::DEF_HDR_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   s_hdr_valid,
    output logic                   s_hdr_ready,
    input  udp_csum_pkg::ip_addr_u s_ip_src,
    input  udp_csum_pkg::ip_addr_u s_ip_dst,
    input  udp_csum_pkg::port_t    s_src_port,
    input  udp_csum_pkg::port_t    s_dst_port,

    input  udp_csum_pkg::byte_t    s_payload_tdata,
    input  logic                   s_payload_tvalid,
    output logic                   s_payload_tready,
    input  logic                   s_payload_tlast,

    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_csum_pkg::ip_addr_u m_ip_src,
    output udp_csum_pkg::ip_addr_u m_ip_dst,
    output udp_csum_pkg::port_t    m_src_port,
    output udp_csum_pkg::port_t    m_dst_port,
    output udp_csum_pkg::word16_t  m_udp_length,
    output udp_csum_pkg::word16_t  m_udp_checksum,

    output udp_csum_pkg::byte_t    m_payload_tdata,
    output logic                   m_payload_tvalid,
    input  logic                   m_payload_tready,
    output logic                   m_payload_tlast
);

    import udp_csum_pkg::*;

    // accumulator to payload FIFO
    byte_t    fifo_in_data;
    logic     fifo_in_valid;
    logic     fifo_in_last;
    logic     fifo_in_ready;

    // accumulator to header queue
    logic     res_valid;
    logic     res_ready;
    ip_addr_u res_ip_src;
    ip_addr_u res_ip_dst;
    port_t    res_src_port;
    port_t    res_dst_port;
    word16_t  res_length;
    word16_t  res_checksum;

    udp_csum_accum u_accum (
        .clk              (clk),
        .rst              (rst),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_ip_src         (s_ip_src),
        .s_ip_dst         (s_ip_dst),
        .s_src_port       (s_src_port),
        .s_dst_port       (s_dst_port),
        .s_payload_tdata  (s_payload_tdata),
        .s_payload_tvalid (s_payload_tvalid),
        .s_payload_tready (s_payload_tready),
        .s_payload_tlast  (s_payload_tlast),
        .fifo_in_data     (fifo_in_data),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_last     (fifo_in_last),
        .fifo_in_ready    (fifo_in_ready),
        .res_valid        (res_valid),
        .res_ready        (res_ready),
        .res_ip_src       (res_ip_src),
        .res_ip_dst       (res_ip_dst),
        .res_src_port     (res_src_port),
        .res_dst_port     (res_dst_port),
        .res_length       (res_length),
        .res_checksum     (res_checksum)
    );

    udp_payload_fifo #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (fifo_in_data),
        .in_last   (fifo_in_last),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (m_payload_tdata),
        .out_last  (m_payload_tlast),
        .out_valid (m_payload_tvalid),
        .out_ready (m_payload_tready)
    );

    udp_hdr_queue #(
        .HDR_DEPTH (HDR_DEPTH)
    ) u_hdr_queue (
        .clk            (clk),
        .rst            (rst),
        .wr_valid       (res_valid),
        .wr_ready       (res_ready),
        .wr_ip_src      (res_ip_src),
        .wr_ip_dst      (res_ip_dst),
        .wr_src_port    (res_src_port),
        .wr_dst_port    (res_dst_port),
        .wr_length      (res_length),
        .wr_checksum    (res_checksum),
        .m_hdr_valid    (m_hdr_valid),
        .m_hdr_ready    (m_hdr_ready),
        .m_ip_src       (m_ip_src),
        .m_ip_dst       (m_ip_dst),
        .m_src_port     (m_src_port),
        .m_dst_port     (m_dst_port),
        .m_udp_length   (m_udp_length),
        .m_udp_checksum (m_udp_checksum)
    );

endmodule

/* udp_checksum_gen_sva.sv */
// output handshake rules of the UDP checksum generator
// bound into every udp_checksum_gen instance
module udp_checksum_gen_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   m_hdr_valid,
    input logic                   m_hdr_ready,
    input udp_csum_pkg::ip_addr_u m_ip_src,
    input udp_csum_pkg::ip_addr_u m_ip_dst,
    input udp_csum_pkg::port_t    m_src_port,
    input udp_csum_pkg::port_t    m_dst_port,
    input udp_csum_pkg::word16_t  m_udp_length,
    input udp_csum_pkg::word16_t  m_udp_checksum,
    input udp_csum_pkg::byte_t    m_payload_tdata,
    input logic                   m_payload_tvalid,
    input logic                   m_payload_tready,
    input logic                   m_payload_tlast
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled header keeps valid and every field
    property hdr_held;
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_ip_src)
            && $stable(m_ip_dst) && $stable(m_src_port) && $stable(m_dst_port)
            && $stable(m_udp_length) && $stable(m_udp_checksum);
    endproperty

    property payload_held;
        @(posedge clk) disable iff (rst)
        m_payload_tvalid && !m_payload_tready |=>
            m_payload_tvalid && $stable(m_payload_tdata) && $stable(m_payload_tlast);
    endproperty

    // sync reset, so outputs are idle from the following edge
    property quiet_in_reset;
        @(posedge clk) rst |=> !m_hdr_valid && !m_payload_tvalid;
    endproperty

    a_hdr_held: assert property (hdr_held)
        else $error("output header changed while m_hdr_ready was low");
    a_payload_held: assert property (payload_held)
        else $error("output payload changed while m_payload_tready was low");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("output valid high during reset");

endmodule

bind udp_checksum_gen udp_checksum_gen_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .m_hdr_valid      (m_hdr_valid),
    .m_hdr_ready      (m_hdr_ready),
    .m_ip_src         (m_ip_src),
    .m_ip_dst         (m_ip_dst),
    .m_src_port       (m_src_port),
    .m_dst_port       (m_dst_port),
    .m_udp_length     (m_udp_length),
    .m_udp_checksum   (m_udp_checksum),
    .m_payload_tdata  (m_payload_tdata),
    .m_payload_tvalid (m_payload_tvalid),
    .m_payload_tready (m_payload_tready),
    .m_payload_tlast  (m_payload_tlast)
);

/* udp_csum_accum.sv */
// captures one header, sums pseudo-header, UDP header and payload
// every frame needs at least one payload byte and a tlast on the last one
// payload must fit in 0xFFF7 bytes, a zero checksum is sent unchanged
module udp_csum_accum (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  s_hdr_valid,
    output logic                  s_hdr_ready,
    input  udp_csum_pkg::ip_addr_u s_ip_src,
    input  udp_csum_pkg::ip_addr_u s_ip_dst,
    input  udp_csum_pkg::port_t   s_src_port,
    input  udp_csum_pkg::port_t   s_dst_port,

    input  udp_csum_pkg::byte_t   s_payload_tdata,
    input  logic                  s_payload_tvalid,
    output logic                  s_payload_tready,
    input  logic                  s_payload_tlast,

    output udp_csum_pkg::byte_t   fifo_in_data,
    output logic                  fifo_in_valid,
    output logic                  fifo_in_last,
    input  logic                  fifo_in_ready,

    output logic                  res_valid,
    input  logic                  res_ready,
    output udp_csum_pkg::ip_addr_u res_ip_src,
    output udp_csum_pkg::ip_addr_u res_ip_dst,
    output udp_csum_pkg::port_t   res_src_port,
    output udp_csum_pkg::port_t   res_dst_port,
    output udp_csum_pkg::word16_t res_length,
    output udp_csum_pkg::word16_t res_checksum
);

    import udp_csum_pkg::*;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_SUM_SRC   = 3'd1;
    localparam logic [2:0] ST_SUM_DST   = 3'd2;
    localparam logic [2:0] ST_SUM_PORTS = 3'd3;
    localparam logic [2:0] ST_PAYLOAD   = 3'd4;
    localparam logic [2:0] ST_FINISH    = 3'd5;
    localparam logic [2:0] ST_DONE      = 3'd6;

    // protocol word plus the header length counted twice
    localparam logic [31:0] SUM_INIT = 32'(UDP_PROTO_WORD) + (32'(UDP_HDR_BYTES) << 1);

    logic [2:0]  state;
    logic [2:0]  state_next;
    logic        hdr_rdy;

    logic        hdr_fire;
    logic        pay_fire;
    logic        in_payload;

    ip_addr_u    ip_src_reg;
    ip_addr_u    ip_dst_reg;
    port_t       src_port_reg;
    port_t       dst_port_reg;
    word16_t     len_reg;
    word16_t     csum_reg;
    logic [31:0] sum_reg;

    logic [15:0] pay_word;
    logic [16:0] fold;

    assign in_payload = (state == ST_PAYLOAD);
    assign hdr_fire = s_hdr_valid && hdr_rdy;
    assign pay_fire = s_payload_tvalid && s_payload_tready;

    assign s_hdr_ready = hdr_rdy;
    assign s_payload_tready = in_payload && fifo_in_ready;

    // bytes pass straight into the FIFO, gated by the payload phase
    assign fifo_in_data = s_payload_tdata;
    assign fifo_in_last = s_payload_tlast;
    assign fifo_in_valid = s_payload_tvalid && in_payload;

    // even offsets land in the high half of a word
    assign pay_word = len_reg[0] ? {8'h00, s_payload_tdata} : {s_payload_tdata, 8'h00};

    // end-around carry
    assign fold = {1'b0, sum_reg[15:0]} + {1'b0, sum_reg[31:16]};

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (hdr_fire) begin
                    state_next = ST_SUM_SRC;
                end
            end
            ST_SUM_SRC:   state_next = ST_SUM_DST;
            ST_SUM_DST:   state_next = ST_SUM_PORTS;
            ST_SUM_PORTS: state_next = ST_PAYLOAD;
            ST_PAYLOAD: begin
                if (pay_fire && s_payload_tlast) begin
                    state_next = ST_FINISH;
                end
            end
            ST_FINISH:    state_next = ST_DONE;
            ST_DONE: begin
                // hold the result until the header queue takes it
                if (res_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default:      state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            hdr_rdy <= 1'b0;
        end else begin
            state <= state_next;
            hdr_rdy <= (state_next == ST_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (hdr_fire) begin
                    ip_src_reg <= s_ip_src;
                    ip_dst_reg <= s_ip_dst;
                    src_port_reg <= s_src_port;
                    dst_port_reg <= s_dst_port;
                    len_reg <= UDP_HDR_BYTES;
                    sum_reg <= SUM_INIT;
                end
            end
            ST_SUM_SRC: begin
                sum_reg <= sum_reg + 32'(ip_src_reg.halves.hi) + 32'(ip_src_reg.halves.lo);
            end
            ST_SUM_DST: begin
                sum_reg <= sum_reg + 32'(ip_dst_reg.halves.hi) + 32'(ip_dst_reg.halves.lo);
            end
            ST_SUM_PORTS: begin
                sum_reg <= sum_reg + 32'(src_port_reg) + 32'(dst_port_reg);
            end
            ST_PAYLOAD: begin
                if (pay_fire) begin
                    // 2 more per byte since the length enters the sum twice
                    sum_reg <= sum_reg + 32'(pay_word) + 32'd2;
                    len_reg <= len_reg + 16'd1;
                end
            end
            ST_FINISH: begin
                csum_reg <= ~(fold[15:0] + 16'(fold[16]));
            end
            default: begin
            end
        endcase
    end

    assign res_valid = (state == ST_DONE);
    assign res_ip_src = ip_src_reg;
    assign res_ip_dst = ip_dst_reg;
    assign res_src_port = src_port_reg;
    assign res_dst_port = dst_port_reg;
    assign res_length = len_reg;
    assign res_checksum = csum_reg;

endmodule

/* udp_csum_pkg.sv */
// shared types and constants for the UDP length and checksum generator
// addresses are IPv4 only, payload is a byte stream
package udp_csum_pkg;

    // one address, read as a whole word or as two 16-bit halves
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } ip_halves_t;

    typedef union packed {
        logic [31:0] word;
        ip_halves_t  halves;
    } ip_addr_u;

    typedef logic [15:0] port_t;

    // length or checksum value
    typedef logic [15:0] word16_t;

    typedef logic [7:0] byte_t;

    // zero-padded protocol number for the pseudo-header
    localparam logic [15:0] UDP_PROTO_WORD = 16'h0011;

    // UDP header size in bytes
    localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

    // default buffer sizes, both must be powers of two
    localparam int DEF_PAYLOAD_DEPTH = 2048;
    localparam int DEF_HDR_DEPTH = 8;

endpackage

/* udp_hdr_queue.sv */
// queue of finished headers with a registered output stage
// HDR_DEPTH must be a power of two and at least 2
module udp_hdr_queue #(
    parameter int HDR_DEPTH = udp_csum_pkg::DEF_HDR_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  udp_csum_pkg::ip_addr_u wr_ip_src,
    input  udp_csum_pkg::ip_addr_u wr_ip_dst,
    input  udp_csum_pkg::port_t    wr_src_port,
    input  udp_csum_pkg::port_t    wr_dst_port,
    input  udp_csum_pkg::word16_t  wr_length,
    input  udp_csum_pkg::word16_t  wr_checksum,

    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_csum_pkg::ip_addr_u m_ip_src,
    output udp_csum_pkg::ip_addr_u m_ip_dst,
    output udp_csum_pkg::port_t    m_src_port,
    output udp_csum_pkg::port_t    m_dst_port,
    output udp_csum_pkg::word16_t  m_udp_length,
    output udp_csum_pkg::word16_t  m_udp_checksum
);

    import udp_csum_pkg::*;

    localparam int AW = $clog2(HDR_DEPTH);
    localparam logic [AW:0] PTR_ONE = 1;

    ip_addr_u    ip_src_mem   [HDR_DEPTH];
    ip_addr_u    ip_dst_mem   [HDR_DEPTH];
    port_t       src_port_mem [HDR_DEPTH];
    port_t       dst_port_mem [HDR_DEPTH];
    word16_t     length_mem   [HDR_DEPTH];
    word16_t     csum_mem     [HDR_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;
    logic        valid_reg;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = !full;
    assign wr_en = wr_valid && !full;
    assign rd_en = !empty && (m_hdr_ready || !valid_reg);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            valid_reg <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_ONE;
                valid_reg <= 1'b1;
            end else if (m_hdr_ready) begin
                // taken and nothing behind it
                valid_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ip_src_mem[wr_ptr[AW-1:0]] <= wr_ip_src;
            ip_dst_mem[wr_ptr[AW-1:0]] <= wr_ip_dst;
            src_port_mem[wr_ptr[AW-1:0]] <= wr_src_port;
            dst_port_mem[wr_ptr[AW-1:0]] <= wr_dst_port;
            length_mem[wr_ptr[AW-1:0]] <= wr_length;
            csum_mem[wr_ptr[AW-1:0]] <= wr_checksum;
        end
        if (rd_en) begin
            m_ip_src <= ip_src_mem[rd_ptr[AW-1:0]];
            m_ip_dst <= ip_dst_mem[rd_ptr[AW-1:0]];
            m_src_port <= src_port_mem[rd_ptr[AW-1:0]];
            m_dst_port <= dst_port_mem[rd_ptr[AW-1:0]];
            m_udp_length <= length_mem[rd_ptr[AW-1:0]];
            m_udp_checksum <= csum_mem[rd_ptr[AW-1:0]];
        end
    end

    assign m_hdr_valid = valid_reg;

endmodule

/* udp_payload_fifo.sv */
// byte FIFO with last flag, registered output stage
// PAYLOAD_DEPTH must be a power of two and at least 2
module udp_payload_fifo #(
    parameter int PAYLOAD_DEPTH = udp_csum_pkg::DEF_PAYLOAD_DEPTH
) (
    input  logic                clk,
    input  logic                rst,

    input  udp_csum_pkg::byte_t in_data,
    input  logic                in_last,
    input  logic                in_valid,
    output logic                in_ready,

    output udp_csum_pkg::byte_t out_data,
    output logic                out_last,
    output logic                out_valid,
    input  logic                out_ready
);

    import udp_csum_pkg::*;

    localparam int AW = $clog2(PAYLOAD_DEPTH);
    localparam logic [AW:0] PTR_ONE = 1;

    byte_t       mem_data [PAYLOAD_DEPTH];
    logic        mem_last [PAYLOAD_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;

    byte_t       out_data_reg;
    logic        out_last_reg;
    logic        out_valid_reg;

    // wrap bits differ with equal index means full
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full;
    assign wr_en = in_valid && !full;

    // refill the output stage when it is empty or being taken
    assign rd_en = !empty && (out_ready || !out_valid_reg);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            out_valid_reg <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_ONE;
                out_valid_reg <= 1'b1;
            end else if (out_ready) begin
                out_valid_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[AW-1:0]] <= in_data;
            mem_last[wr_ptr[AW-1:0]] <= in_last;
        end
        if (rd_en) begin
            out_data_reg <= mem_data[rd_ptr[AW-1:0]];
            out_last_reg <= mem_last[rd_ptr[AW-1:0]];
        end
    end

    assign out_data = out_data_reg;
    assign out_last = out_last_reg;
    assign out_valid = out_valid_reg;

endmodule
